// File: rtl/adpcm_cfg_pkg.sv
//**********************************************************
// ADPCM-A configuration package
// host register map, per-channel setup and ROM address types
//**********************************************************
package adpcm_cfg_pkg;

    typedef logic [19:0] byte_addr_t;   // rom byte address
    typedef logic [20:0] nib_addr_t;    // byte address, bit 0 picks low nibble
    typedef logic [11:0] block_t;       // 256-byte block number

    typedef enum logic [1:0] {
        REG_START,
        REG_END,
        REG_PANLVL,
        REG_KEY
    } reg_sel_t;

    typedef struct packed {
        block_t     start;
        block_t     stop;
        logic       pan_l;
        logic       pan_r;
        logic [4:0] level;
    } ch_cfg_t;

    localparam int KEY_DUMP_BIT = 7;    // set means key off

endpackage

// File: rtl/adpcm_audio_pkg.sv
//**********************************************************
// ADPCM-A audio package
// sample widths, reduced step table, index adjust table
// and the slot record passed from scheduler to decoder
//**********************************************************
package adpcm_audio_pkg;

    typedef logic [3:0]         nibble_t;
    typedef logic signed [15:0] pcm_t;
    typedef logic [3:0]         step_idx_t;

    // 16-entry stand-in for the real 49-step table
    localparam logic [11:0] STEP_TABLE [16] = '{
        12'd16,  12'd19,  12'd23,  12'd28,
        12'd34,  12'd41,  12'd50,  12'd60,
        12'd73,  12'd88,  12'd107, 12'd130,
        12'd157, 12'd190, 12'd230, 12'd279
    };

    localparam logic signed [4:0] IDX_ADJ [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1,
        5'sd2,  5'sd4,  5'sd6,  5'sd8
    };

    typedef struct packed {
        logic [2:0] ch;
        nibble_t    nib;
        logic       valid;
    } slot_t;

endpackage

// File: rtl/adpcm_reg_decode.sv
//**********************************************************
// ADPCM-A host register decode
// per-channel start, end, pan and level registers, and
// key writes split into key-on and key-off pulses
//**********************************************************
`timescale 1ns/1ps

module adpcm_reg_decode #(
    parameter int NUM_CH = 6
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     reg_we,
    input  adpcm_cfg_pkg::reg_sel_t  reg_sel,
    input  logic [2:0]               reg_ch,
    input  logic [15:0]              reg_data,
    output adpcm_cfg_pkg::ch_cfg_t   cfg [NUM_CH],
    output logic [NUM_CH-1:0]        key_on,
    output logic [NUM_CH-1:0]        key_off
);
    import adpcm_cfg_pkg::*;

    logic [7:0]        mask_ext;
    logic [NUM_CH-1:0] key_mask;
    logic              key_wr;
    logic              dump;

    assign mask_ext = {2'b00, reg_data[5:0]};     // mask is bits 5:0
    assign key_mask = mask_ext[NUM_CH-1:0];
    assign key_wr   = reg_we && (reg_sel == REG_KEY);
    assign dump     = reg_data[KEY_DUMP_BIT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_on  <= '0;
            key_off <= '0;
        end else begin
            key_on  <= (key_wr && !dump) ? key_mask : '0;  // single clock pulses
            key_off <= (key_wr && dump) ? key_mask : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                cfg[i] <= '0;
            end
        end else if (reg_we) begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (reg_ch == 3'(i)) begin
                    case (reg_sel)
                        REG_START: cfg[i].start <= reg_data[11:0];
                        REG_END:   cfg[i].stop  <= reg_data[11:0];
                        REG_PANLVL: begin
                            cfg[i].pan_l <= reg_data[7];
                            cfg[i].pan_r <= reg_data[6];
                            cfg[i].level <= reg_data[4:0];
                        end
                        default: ;                    // key writes ignore reg_ch
                    endcase
                end
            end
        end
    end

endmodule

// File: rtl/adpcm_ch_counter.sv
//**********************************************************
// ADPCM-A channel address counter
// walks one channel from its start block to the last
// nibble of its end block, with active and end flags
//**********************************************************
`timescale 1ns/1ps

module adpcm_ch_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  adpcm_cfg_pkg::block_t     start,
    input  adpcm_cfg_pkg::block_t     stop,
    input  logic                      key_on,
    input  logic                      key_off,
    input  logic                      adv,        // nibble consumed
    output adpcm_cfg_pkg::nib_addr_t  nib_addr,
    output logic                      active,
    output logic                      end_flag
);
    import adpcm_cfg_pkg::*;

    byte_addr_t end_byte;
    logic       at_end;

    assign end_byte = {stop, 8'hff};          // last byte of end block
    assign at_end   = (nib_addr[20:1] == end_byte) && nib_addr[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nib_addr <= '0;
            active   <= 1'b0;
            end_flag <= 1'b0;
        end else if (key_on) begin
            nib_addr <= {start, 9'd0};        // start x 512 nibbles
            active   <= 1'b1;
            end_flag <= 1'b0;
        end else if (key_off) begin
            active <= 1'b0;                   // dump leaves end flag alone
        end else if (adv && active) begin
            if (at_end) begin
                active   <= 1'b0;
                end_flag <= 1'b1;
            end else begin
                nib_addr <= nib_addr + 1'b1;
            end
        end
    end

endmodule

// File: rtl/adpcm_slot_sched.sv
//**********************************************************
// ADPCM-A slot scheduler
// serves one channel per cen, drives the ROM address and
// picks the fetched nibble one cen later
//**********************************************************
`timescale 1ns/1ps

module adpcm_slot_sched #(
    parameter int NUM_CH = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,
    input  adpcm_cfg_pkg::nib_addr_t   nib_addr [NUM_CH],
    input  logic [NUM_CH-1:0]          active,
    input  logic [7:0]                 rom_data,
    output adpcm_cfg_pkg::byte_addr_t  rom_addr,
    output logic [NUM_CH-1:0]          adv,
    output adpcm_audio_pkg::slot_t     slot
);
    import adpcm_audio_pkg::*;

    logic [2:0] slot_cnt;                     // channel addressed this cen
    logic [2:0] prev_ch;                      // channel whose byte is on rom_data
    logic       prev_low;
    logic       prev_act;
    nibble_t    nib_sel;

    assign nib_sel = prev_low ? rom_data[3:0] : rom_data[7:4];

    always_comb begin
        adv = '0;
        if (cen && prev_act) begin
            adv[prev_ch] = active[prev_ch];   // skip if dumped meanwhile
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt <= '0;
            prev_ch  <= '0;
            prev_low <= 1'b0;
            prev_act <= 1'b0;
            rom_addr <= '0;
            slot     <= '0;
        end else if (cen) begin
            slot.ch    <= prev_ch;
            slot.nib   <= nib_sel;
            slot.valid <= prev_act;
            rom_addr   <= nib_addr[slot_cnt][20:1];
            prev_low   <= nib_addr[slot_cnt][0];
            prev_act   <= active[slot_cnt];
            prev_ch    <= slot_cnt;
            slot_cnt   <= (slot_cnt == 3'(NUM_CH - 1)) ? '0 : slot_cnt + 1'b1;
        end
    end

endmodule

// File: rtl/adpcm_decoder.sv
//**********************************************************
// ADPCM-A decoder
// per-channel predictor and step index, updated once for
// every valid slot from the scheduler
//**********************************************************
`timescale 1ns/1ps

module adpcm_decoder #(
    parameter int NUM_CH = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cen,
    input  adpcm_audio_pkg::slot_t  slot,
    input  logic [NUM_CH-1:0]       key_on,
    output logic [2:0]              dec_ch,
    output adpcm_audio_pkg::pcm_t   dec_pcm,
    output logic                    dec_valid,
    output logic                    dec_last    // slot of the last channel
);
    import adpcm_audio_pkg::*;

    pcm_t               pred [NUM_CH];
    step_idx_t          idx [NUM_CH];
    logic               slot_new;             // slot refreshed on last cen
    logic [2:0]         mag;
    logic [15:0]        prod;
    logic [15:0]        diff;
    logic signed [17:0] sum;
    pcm_t               pred_nxt;
    logic signed [5:0]  idx_sum;
    step_idx_t          idx_nxt;

    always_comb begin
        mag  = slot.nib[2:0];
        prod = 16'(STEP_TABLE[idx[slot.ch]]) * 16'({mag, 1'b1});   // step x (2m+1)
        diff = prod >> 3;
        if (slot.nib[3]) begin
            sum = 18'(pred[slot.ch]) - $signed({2'b00, diff});
        end else begin
            sum = 18'(pred[slot.ch]) + $signed({2'b00, diff});
        end
        if (sum > 18'sd32767) begin
            pred_nxt = 16'sh7fff;
        end else if (sum < -18'sd32768) begin
            pred_nxt = 16'sh8000;
        end else begin
            pred_nxt = sum[15:0];
        end
        idx_sum = $signed({2'b00, idx[slot.ch]}) + 6'(IDX_ADJ[mag]);
        if (idx_sum < 0) begin
            idx_nxt = '0;
        end else if (idx_sum > 6'sd15) begin
            idx_nxt = 4'd15;
        end else begin
            idx_nxt = idx_sum[3:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_new  <= 1'b0;
            dec_ch    <= '0;
            dec_pcm   <= '0;
            dec_valid <= 1'b0;
            dec_last  <= 1'b0;
            for (int i = 0; i < NUM_CH; i++) begin
                pred[i] <= '0;
                idx[i]  <= '0;
            end
        end else begin
            slot_new  <= cen;
            dec_valid <= slot_new && slot.valid;
            dec_last  <= slot_new && (slot.ch == 3'(NUM_CH - 1));
            if (slot_new) begin
                dec_ch <= slot.ch;
            end
            if (slot_new && slot.valid) begin
                pred[slot.ch] <= pred_nxt;
                idx[slot.ch]  <= idx_nxt;
                dec_pcm       <= pred_nxt;
            end
            for (int i = 0; i < NUM_CH; i++) begin
                if (key_on[i]) begin          // key-on wins over a decode
                    pred[i] <= '0;
                    idx[i]  <= '0;
                end
            end
        end
    end

endmodule

// File: rtl/adpcm_mixer.sv
//**********************************************************
// ADPCM-A stereo mixer
// pan and level per channel, one sum per round of slots,
// global attenuation with saturation to 16 bits
//**********************************************************
`timescale 1ns/1ps

module adpcm_mixer #(
    parameter int NUM_CH = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [2:0]              dec_ch,
    input  adpcm_audio_pkg::pcm_t   dec_pcm,
    input  logic                    dec_valid,
    input  logic                    dec_last,
    input  adpcm_cfg_pkg::ch_cfg_t  cfg [NUM_CH],
    input  logic [2:0]              atl,
    output adpcm_audio_pkg::pcm_t   pcm_l,
    output adpcm_audio_pkg::pcm_t   pcm_r,
    output logic                    sample_valid
);
    import adpcm_audio_pkg::*;

    typedef logic signed [19:0] acc_t;        // room for eight full channels

    acc_t acc_l, acc_r;
    acc_t add_l, add_r;
    acc_t tot_l, tot_r;

    function automatic acc_t scale(input pcm_t s, input logic [4:0] lvl);
        logic signed [21:0] p;
        p = s * $signed({1'b0, lvl});
        return acc_t'(p >>> 5);               // level / 32
    endfunction

    function automatic pcm_t sat16(input acc_t v);
        if (v > 20'sd32767) begin
            return 16'sh7fff;
        end else if (v < -20'sd32768) begin
            return 16'sh8000;
        end else begin
            return v[15:0];
        end
    endfunction

    always_comb begin
        add_l = '0;
        add_r = '0;
        if (dec_valid && cfg[dec_ch].pan_l) begin
            add_l = scale(dec_pcm, cfg[dec_ch].level);
        end
        if (dec_valid && cfg[dec_ch].pan_r) begin
            add_r = scale(dec_pcm, cfg[dec_ch].level);
        end
        tot_l = acc_l + add_l;
        tot_r = acc_r + add_r;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_l        <= '0;
            acc_r        <= '0;
            pcm_l        <= '0;
            pcm_r        <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= dec_last;
            if (dec_last) begin               // round complete
                pcm_l <= sat16(tot_l >>> atl);
                pcm_r <= sat16(tot_r >>> atl);
                acc_l <= '0;
                acc_r <= '0;
            end else begin
                acc_l <= tot_l;
                acc_r <= tot_r;
            end
        end
    end

endmodule

// File: rtl/adpcm_a_top.sv
//**********************************************************
// ADPCM-A sample playback top
// host registers, channel counters, slot scheduler,
// decoder and stereo mixer
//**********************************************************
`timescale 1ns/1ps

module adpcm_a_top #(
    parameter int NUM_CH = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,           // one slot per strobe
    input  logic                       reg_we,
    input  adpcm_cfg_pkg::reg_sel_t    reg_sel,
    input  logic [2:0]                 reg_ch,
    input  logic [15:0]                reg_data,
    input  logic [2:0]                 atl,           // global attenuation
    output adpcm_cfg_pkg::byte_addr_t  rom_addr,
    input  logic [7:0]                 rom_data,
    output adpcm_audio_pkg::pcm_t      pcm_l,
    output adpcm_audio_pkg::pcm_t      pcm_r,
    output logic                       sample_valid,
    output logic [NUM_CH-1:0]          end_flags
);
    import adpcm_cfg_pkg::*;
    import adpcm_audio_pkg::*;

    ch_cfg_t           cfg [NUM_CH];
    nib_addr_t         nib_addr [NUM_CH];
    logic [NUM_CH-1:0] key_on;
    logic [NUM_CH-1:0] key_off;
    logic [NUM_CH-1:0] active;
    logic [NUM_CH-1:0] adv;
    slot_t             slot;
    logic [2:0]        dec_ch;
    pcm_t              dec_pcm;
    logic              dec_valid;
    logic              dec_last;

    adpcm_reg_decode #(.NUM_CH(NUM_CH)) u_regs (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .reg_we   ( reg_we   ),
        .reg_sel  ( reg_sel  ),
        .reg_ch   ( reg_ch   ),
        .reg_data ( reg_data ),
        .cfg      ( cfg      ),
        .key_on   ( key_on   ),
        .key_off  ( key_off  )
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        adpcm_ch_counter u_cnt (
            .clk      ( clk          ),
            .rst_n    ( rst_n        ),
            .start    ( cfg[i].start ),
            .stop     ( cfg[i].stop  ),
            .key_on   ( key_on[i]    ),
            .key_off  ( key_off[i]   ),
            .adv      ( adv[i]       ),
            .nib_addr ( nib_addr[i]  ),
            .active   ( active[i]    ),
            .end_flag ( end_flags[i] )
        );
    end

    adpcm_slot_sched #(.NUM_CH(NUM_CH)) u_sched (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .nib_addr ( nib_addr ),
        .active   ( active   ),
        .rom_data ( rom_data ),
        .rom_addr ( rom_addr ),
        .adv      ( adv      ),
        .slot     ( slot     )
    );

    adpcm_decoder #(.NUM_CH(NUM_CH)) u_dec (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cen       ( cen       ),
        .slot      ( slot      ),
        .key_on    ( key_on    ),
        .dec_ch    ( dec_ch    ),
        .dec_pcm   ( dec_pcm   ),
        .dec_valid ( dec_valid ),
        .dec_last  ( dec_last  )
    );

    adpcm_mixer #(.NUM_CH(NUM_CH)) u_mix (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .dec_ch       ( dec_ch       ),
        .dec_pcm      ( dec_pcm      ),
        .dec_valid    ( dec_valid    ),
        .dec_last     ( dec_last     ),
        .cfg          ( cfg          ),
        .atl          ( atl          ),
        .pcm_l        ( pcm_l        ),
        .pcm_r        ( pcm_r        ),
        .sample_valid ( sample_valid )
    );

endmodule

// File: verification/adpcm_a_sva.sv
//**********************************************************
// ADPCM-A scheduler and counter assertions
// advance strobes and active flag rules
//**********************************************************
`timescale 1ns/1ps

module adpcm_a_sva #(
    parameter int W          = 6,
    parameter bit ON_COUNTER = 1'b0     // bound to one channel counter
) (
    input logic         clk,
    input logic         rst_n,
    input logic [W-1:0] adv,
    input logic [W-1:0] active,
    input logic [W-1:0] key_on
);
    for (genvar i = 0; i < W; i++) begin : g_ch
        assert property (@(posedge clk) disable iff (!rst_n) adv[i] |-> active[i])
            else $error("adv on inactive channel %0d", i);
    end

    if (ON_COUNTER) begin : g_key
        for (genvar i = 0; i < W; i++) begin : g_bit
            assert property (@(posedge clk) disable iff (!rst_n)
                             $rose(active[i]) |-> $past(key_on[i]))
                else $error("channel %0d went active without key-on", i);
        end
    end else begin : g_sched
        assert property (@(posedge clk) disable iff (!rst_n) $onehot0(adv))
            else $error("adv is not one-hot");
    end

endmodule

bind adpcm_slot_sched adpcm_a_sva #(.W(NUM_CH), .ON_COUNTER(1'b0)) u_sva (
    .clk(clk), .rst_n(rst_n), .adv(adv), .active(active), .key_on('0)
);

bind adpcm_ch_counter adpcm_a_sva #(.W(1), .ON_COUNTER(1'b1)) u_sva (
    .clk(clk), .rst_n(rst_n), .adv(adv), .active(active), .key_on(key_on)
);

// File: verification/tb_adpcm_a.sv
//**********************************************************
// ADPCM-A playback testbench
// ROM model, reference decoder and mixer, directed tests
// for reset, decode, end of sample, key-off and mixing
//**********************************************************
`timescale 1ns/1ps

module tb_adpcm_a;
    import adpcm_cfg_pkg::*;
    import adpcm_audio_pkg::*;

    localparam int NUM_CH     = 6;
    localparam int ROUNDS     = 960;                   // sample rounds over all tests
    localparam int TIMEOUT_NS = ROUNDS * NUM_CH * 40 + 20000;

    logic clk = 1'b0, rst_n = 1'b0, cen = 1'b0, reg_we = 1'b0;
    reg_sel_t reg_sel = REG_START;
    logic [2:0] reg_ch = '0, atl = '0;
    logic [15:0] reg_data = '0;
    logic [7:0] rom_data = '0;
    byte_addr_t rom_addr;
    pcm_t pcm_l, pcm_r;
    logic sample_valid;
    logic [NUM_CH-1:0] end_flags;

    logic [7:0] rom [65536];
    logic [31:0] lcg_state = 32'hce89_5c37;
    int mismatches = 0, other_errors = 0, n_samples = 0, phase = 0, sel_cnt = 0;
    int m_pred [NUM_CH], m_idx [NUM_CH], m_lvl [NUM_CH];
    logic [20:0] m_addr [NUM_CH];
    logic [11:0] m_start [NUM_CH], m_stop [NUM_CH];
    logic [NUM_CH-1:0] m_active = '0, m_end = '0, m_pl = '0, m_pr = '0;
    int acc_l = 0, acc_r = 0;
    int exp_l [$], exp_r [$];
    logic [19:0] exp_rom = '0;
    int exp_ch = 0;
    logic exp_rom_ok = 1'b0, wr_pend = 1'b0;
    reg_sel_t wr_sel = REG_START;
    logic [2:0] wr_ch = '0;
    logic [15:0] wr_data = '0;

    adpcm_a_top #(.NUM_CH(NUM_CH)) UUT (
        .clk(clk), .rst_n(rst_n), .cen(cen), .reg_we(reg_we), .reg_sel(reg_sel),
        .reg_ch(reg_ch), .reg_data(reg_data), .atl(atl), .rom_addr(rom_addr),
        .rom_data(rom_data), .pcm_l(pcm_l), .pcm_r(pcm_r),
        .sample_valid(sample_valid), .end_flags(end_flags)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int sat16(input int v);
        return (v > 32767) ? 32767 : ((v < -32768) ? -32768 : v);
    endfunction

    // reference ADPCM step for one nibble
    function automatic void ref_decode(input int ch, input logic [3:0] nib);
        int mag, diff;
        mag  = int'(nib[2:0]);
        diff = (int'(STEP_TABLE[m_idx[ch]]) * (2 * mag + 1)) / 8;
        m_pred[ch] = sat16(nib[3] ? m_pred[ch] - diff : m_pred[ch] + diff);
        m_idx[ch]  = m_idx[ch] + int'(IDX_ADJ[mag]);
        m_idx[ch]  = (m_idx[ch] < 0) ? 0 : ((m_idx[ch] > 15) ? 15 : m_idx[ch]);
    endfunction

    always #5 clk = ~clk;

    always @(posedge clk) begin
        phase <= (phase + 1) % 4;
        cen   <= rst_n && (phase == 3);                  // one strobe every 4 clocks
        rom_data <= rom[rom_addr[15:0]];                 // one clock ROM latency
    end

    // model serves channel sel_cnt at every strobe
    always @(posedge clk) begin : model
        logic [19:0] byte_a;
        logic [3:0]  nib;
        if (!rst_n) begin
            sel_cnt = 0;
        end else begin
            if (cen) begin
                if (exp_rom_ok) begin
                    assert (rom_addr == exp_rom) else begin
                        $display("Mismatch at %0t: rom_addr %h, expected %h", $time,
                                 rom_addr, exp_rom);
                        mismatches++;
                    end
                    assert (rom_addr >= {m_start[exp_ch], 8'h00} &&
                            rom_addr <= {m_stop[exp_ch], 8'hff}) else begin
                        $display("Mismatch at %0t: rom_addr %h out of range for channel %0d",
                                 $time, rom_addr, exp_ch);
                        mismatches++;
                    end
                end
                exp_rom_ok = 1'b0;
                if (m_active[sel_cnt]) begin
                    byte_a  = m_addr[sel_cnt][20:1];
                    nib     = m_addr[sel_cnt][0] ? rom[byte_a[15:0]][3:0]
                                                 : rom[byte_a[15:0]][7:4];
                    exp_rom = byte_a;
                    exp_ch  = sel_cnt;
                    exp_rom_ok = 1'b1;
                    ref_decode(sel_cnt, nib);
                    if (m_pl[sel_cnt]) acc_l += (m_pred[sel_cnt] * m_lvl[sel_cnt]) >>> 5;
                    if (m_pr[sel_cnt]) acc_r += (m_pred[sel_cnt] * m_lvl[sel_cnt]) >>> 5;
                    if (m_addr[sel_cnt] == {m_stop[sel_cnt], 8'hff, 1'b1}) begin
                        m_active[sel_cnt] = 1'b0;
                        m_end[sel_cnt]    = 1'b1;
                    end else begin
                        m_addr[sel_cnt] = m_addr[sel_cnt] + 21'd1;
                    end
                end
                if (sel_cnt == NUM_CH - 1) begin         // round complete
                    exp_l.push_back(acc_l);
                    exp_r.push_back(acc_r);
                    acc_l = 0;
                    acc_r = 0;
                    sel_cnt = 0;
                end else begin
                    sel_cnt++;
                end
            end
            if (wr_pend) begin                           // reaches counters one clock later
                for (int i = 0; i < NUM_CH; i++) begin
                    if (wr_sel == REG_KEY && wr_data[i] && !wr_data[KEY_DUMP_BIT]) begin
                        m_addr[i] = {m_start[i], 9'd0};
                        m_active[i] = 1'b1;
                        m_end[i] = 1'b0;
                        m_pred[i] = 0;
                        m_idx[i] = 0;
                    end else if (wr_sel == REG_KEY && wr_data[i]) begin
                        m_active[i] = 1'b0;
                    end else if (wr_sel != REG_KEY && wr_ch == 3'(i)) begin
                        if (wr_sel == REG_START) m_start[i] = wr_data[11:0];
                        if (wr_sel == REG_END) m_stop[i] = wr_data[11:0];
                        if (wr_sel == REG_PANLVL) begin
                            m_pl[i] = wr_data[7];
                            m_pr[i] = wr_data[6];
                            m_lvl[i] = int'(wr_data[4:0]);
                        end
                    end
                end
            end
            wr_pend = reg_we;
            wr_sel  = reg_sel;
            wr_ch   = reg_ch;
            wr_data = reg_data;
        end
    end

    // every strobe is checked against the oldest modeled round
    always @(posedge clk) begin
        if (rst_n && sample_valid) begin
            if (exp_l.size() == 0) begin
                $display("sample_valid at %0t with no completed round", $time);
                other_errors++;
            end else begin
                assert (int'(pcm_l) == sat16(exp_l[0] >>> atl) &&
                        int'(pcm_r) == sat16(exp_r[0] >>> atl)) else begin
                    $display("Mismatch at %0t: pcm %0d/%0d, expected %0d/%0d", $time,
                             pcm_l, pcm_r, sat16(exp_l[0] >>> atl), sat16(exp_r[0] >>> atl));
                    mismatches++;
                end
                void'(exp_l.pop_front());
                void'(exp_r.pop_front());
            end
            n_samples++;
        end
    end

    task automatic write_reg(input reg_sel_t sel, input logic [2:0] ch, input logic [15:0] d);
        @(posedge clk);
        reg_we <= 1'b1;
        reg_sel <= sel;
        reg_ch <= ch;
        reg_data <= d;
        @(posedge clk);
        reg_we <= 1'b0;
    endtask

    task automatic wait_samples(input int n);
        int target;
        target = n_samples + n;
        while (n_samples < target) @(posedge clk);
    endtask

    task automatic setup_ch(input int ch, input int blk_s, input int blk_e,
                            input logic [15:0] panlvl);
        write_reg(REG_START, 3'(ch), 16'(blk_s));
        write_reg(REG_END, 3'(ch), 16'(blk_e));
        write_reg(REG_PANLVL, 3'(ch), panlvl);
    endtask

    task automatic check_flags();
        assert (end_flags == m_end) else begin
            $display("Mismatch at %0t: end_flags %b, expected %b", $time, end_flags, m_end);
            mismatches++;
        end
    endtask

    task automatic reset_outputs();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (pcm_l == 0 && pcm_r == 0 && end_flags == 0 && rom_addr == 0) else begin
            $display("Mismatch at %0t: outputs not cleared after reset", $time);
            mismatches++;
        end
        wait_samples(5);
    endtask

    task automatic decode_single();
        setup_ch(2, 1, 2, 16'h00df);                     // both pans at level 31
        write_reg(REG_KEY, 3'd0, 16'h0004);
        wait_samples(40);
    endtask

    task automatic play_to_end();
        write_reg(REG_KEY, 3'd0, 16'h00bf);
        wait_samples(2);
        setup_ch(0, 3, 3, 16'h0090);
        write_reg(REG_KEY, 3'd0, 16'h0001);
        wait_samples(520);
        check_flags();
        assert (end_flags[0]) else begin
            $display("Mismatch at %0t: end flag of channel 0 did not set", $time);
            mismatches++;
        end
    endtask

    task automatic dump_and_restart();
        setup_ch(1, 4, 5, 16'h0054);
        setup_ch(3, 6, 6, 16'h00ca);
        write_reg(REG_KEY, 3'd0, 16'h000a);
        wait_samples(10);
        write_reg(REG_KEY, 3'd0, 16'h0082);              // dump channel 1 only
        wait_samples(10);
        check_flags();
        write_reg(REG_KEY, 3'd0, 16'h0002);
        wait_samples(15);
    endtask

    task automatic mix_channels();
        write_reg(REG_KEY, 3'd0, 16'h00bf);
        wait_samples(2);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            setup_ch(ch, 8 + ch, 8 + ch, 16'((ch % 3 == 0) ? 8'hc0 : ((ch % 3 == 1) ? 8'h80
                     : 8'h40)) | 16'(31 - 3 * ch));
        end
        atl <= 3'd2;
        write_reg(REG_KEY, 3'd0, 16'h003f);
        wait_samples(150);
        atl <= 3'd0;                                     // sums clip without attenuation
        wait_samples(150);
        check_flags();
    endtask

    initial begin
        for (int i = 0; i < 65536; i++) begin
            lcg_state = lcg_next(lcg_state);
            rom[i] = lcg_state[31:24];
            if (i >= 'h800 && i < 'he00) begin
                rom[i] = rom[i] & 8'h77;                 // mixing blocks hold rising nibbles only
            end
        end
        reset_outputs();
        decode_single();
        play_to_end();
        dump_and_restart();
        mix_channels();
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, run did not complete", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: list.f
rtl/adpcm_cfg_pkg.sv
rtl/adpcm_audio_pkg.sv
rtl/adpcm_reg_decode.sv
rtl/adpcm_ch_counter.sv
rtl/adpcm_slot_sched.sv
rtl/adpcm_decoder.sv
rtl/adpcm_mixer.sv
rtl/adpcm_a_top.sv
verification/adpcm_a_sva.sv
verification/tb_adpcm_a.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ADPCM-A testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_adpcm_a -o sim_adpcm_a
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_adpcm_a)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
